//--- Bender.yml
package:
  name: csr_unit

sources:
  - hdl/csr_pkg.sv
  - hdl/csr_ifs.sv
  - hdl/csr_decode.sv
  - hdl/csr_file.sv
  - hdl/csr_result.sv
  - hdl/csr_unit_top.sv
  - target: test
    files:
      - testbench/csr_unit_checker.sv
      - testbench/csr_unit_tb.sv

//--- hdl/csr_decode.sv
`timescale 1ns/1ps

module csr_decode import csr_pkg::*; (
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_data,
    csr_req_if.source   req
);

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] imm;
    csr_f3_e     funct3;
    csr_op_e     op;
    logic        is_csr;
    logic        addr_ok;

    // Instruction fields in the I-type layout.
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = csr_f3_e'(instr[14:12]);
    assign rs1    = instr[19:15];
    assign imm    = instr[31:20];

    // Map SYSTEM funct3 onto an operation.
    // Anything not recognised stays op_none and is flagged below.
    always_comb begin
        op = op_none;
        if (opcode == opcode_system) begin
            case (funct3)
                f3_rw, f3_rwi: op = op_rw;
                f3_rs, f3_rsi: op = op_rs;
                f3_rc, f3_rci: op = op_rc;
                f3_priv: begin
                    // ecall and mret share funct3 and differ in the immediate.
                    if (imm == 12'h000) begin
                        op = op_ecall;
                    end else if (imm == 12'h302) begin
                        op = op_mret;
                    end
                end
                default: op = op_none;
            endcase
        end
    end

    assign is_csr = (op == op_rw) || (op == op_rs) || (op == op_rc);

    // Only the four implemented CSRs are accepted.
    always_comb begin
        case (imm)
            addr_mstatus, addr_mtvec, addr_mepc, addr_mcause: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    assign req.valid   = instr_valid;
    assign req.op      = op;
    assign req.addr    = imm;
    assign req.pc      = pc;
    // Immediate forms carry a zero-extended 5-bit value in the rs1 field.
    assign req.operand = instr[14] ? {27'd0, rs1} : rs1_data;
    // Set and clear with a zero source leave the CSR alone.
    assign req.write_csr = instr_valid && is_csr && addr_ok && ((op == op_rw) || (rs1 != 5'd0));
    assign req.rd_we     = instr_valid && is_csr && (rd != 5'd0);
    // Unknown encodings and bad CSR addresses.
    assign req.illegal   = instr_valid && ((op == op_none) || (is_csr && !addr_ok));

endmodule

//--- hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file import csr_pkg::*; #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       reset,
    csr_req_if.sink    req,
    csr_rsp_if.source  rsp
);

    logic [31:0] mstatus;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] old_value;
    logic [31:0] new_value;
    logic        accept;

    // Request that may touch state.
    assign accept = req.valid && !req.illegal;

    // Read port returns the value before any update this cycle.
    always_comb begin
        case (req.addr)
            addr_mstatus: old_value = mstatus;
            addr_mtvec:   old_value = mtvec;
            addr_mepc:    old_value = mepc;
            addr_mcause:  old_value = mcause;
            default:      old_value = 32'd0;
        endcase
    end

    // Read-modify-write value.
    always_comb begin
        case (req.op)
            op_rs:   new_value = old_value | req.operand;
            op_rc:   new_value = old_value & ~req.operand;
            default: new_value = req.operand;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus <= mstatus_fixed;
            mtvec   <= MTVEC_RESET;
            mepc    <= 32'd0;
            mcause  <= 32'd0;
        end else if (accept) begin
            if (req.write_csr) begin
                case (req.addr)
                    // mstatus and mcause are pinned to fixed values.
                    addr_mstatus: mstatus <= mstatus_fixed;
                    addr_mtvec:   mtvec   <= new_value;
                    addr_mepc:    mepc    <= new_value;
                    addr_mcause:  mcause  <= mcause_ecall;
                    default: begin
                    end
                endcase
            end else if (req.op == op_ecall) begin
                // Trap entry saves the faulting pc.
                mepc   <= req.pc;
                mcause <= mcause_ecall;
            end
        end
    end

    assign rsp.valid     = req.valid;
    assign rsp.old_value = old_value;
    assign rsp.rd_we     = req.rd_we && !req.illegal;
    assign rsp.take_trap = accept && (req.op == op_ecall);
    assign rsp.take_mret = accept && (req.op == op_mret);
    // Redirect targets as seen before this cycle's update.
    assign rsp.mtvec     = mtvec;
    assign rsp.mepc      = mepc;
    assign rsp.illegal   = req.illegal;

    // A trap or a return never arrives together with a CSR write.
    // The write would otherwise hide the ecall save above.
    a_ctrl_no_write: assert property (
        @(posedge clk) disable iff (reset)
        !(req.write_csr && ((req.op == op_ecall) || (req.op == op_mret)))
    );

    // Decode must never let a rejected request write.
    a_illegal_no_write: assert property (
        @(posedge clk) disable iff (reset) !(req.illegal && req.write_csr)
    );

endmodule

//--- hdl/csr_ifs.sv
`timescale 1ns/1ps

// Decoded CSR request, decode to CSR file.
interface csr_req_if import csr_pkg::*; ();
    logic        valid;
    csr_op_e     op;
    logic [11:0] addr;
    logic [31:0] operand;
    logic        write_csr;
    logic        rd_we;
    logic        illegal;
    logic [31:0] pc;

    modport source (output valid, op, addr, operand, write_csr, rd_we, illegal, pc);
    modport sink   (input  valid, op, addr, operand, write_csr, rd_we, illegal, pc);
endinterface

// CSR file response, CSR file to result stage.
interface csr_rsp_if ();
    logic        valid;
    logic [31:0] old_value;
    logic        rd_we;
    logic        take_trap;
    logic        take_mret;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic        illegal;

    modport source (
        output valid, old_value, rd_we, take_trap, take_mret, mtvec, mepc, illegal
    );
    modport sink (
        input valid, old_value, rd_we, take_trap, take_mret, mtvec, mepc, illegal
    );
endinterface

//--- hdl/csr_pkg.sv
package csr_pkg;

    // Machine-mode CSR addresses handled by the unit.
    typedef enum logic [11:0] {
        addr_mstatus = 12'h300,
        addr_mtvec   = 12'h305,
        addr_mepc    = 12'h341,
        addr_mcause  = 12'h342
    } csr_addr_e;

    // Operation carried from decode to the CSR file.
    typedef enum logic [2:0] {
        op_none  = 3'd0,
        op_rw    = 3'd1,
        op_rs    = 3'd2,
        op_rc    = 3'd3,
        op_ecall = 3'd4,
        op_mret  = 3'd5
    } csr_op_e;

    // SYSTEM funct3 encodings.
    // Bit 2 selects the immediate forms.
    typedef enum logic [2:0] {
        f3_priv = 3'b000,
        f3_rw   = 3'b001,
        f3_rs   = 3'b010,
        f3_rc   = 3'b011,
        f3_rwi  = 3'b101,
        f3_rsi  = 3'b110,
        f3_rci  = 3'b111
    } csr_f3_e;

    // SYSTEM major opcode.
    localparam logic [6:0] opcode_system = 7'b1110011;

    // Any mstatus write lands on this value (MPP = machine).
    localparam logic [31:0] mstatus_fixed = 32'h0000_1800;

    // Cause code for ecall from M-mode, also the value of any mcause write.
    localparam logic [31:0] mcause_ecall = 32'h0000_000b;

endpackage

//--- hdl/csr_result.sv
`timescale 1ns/1ps

module csr_result (
    input  logic        clk,
    input  logic        reset,
    csr_rsp_if.sink     rsp,
    output logic        out_valid,
    output logic        rd_we,
    output logic [31:0] rd_data,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic        illegal
);

    logic [31:0] target;

    // ecall jumps to the handler, mret back to the saved pc.
    always_comb begin
        if (rsp.take_trap) begin
            target = rsp.mtvec;
        end else if (rsp.take_mret) begin
            target = rsp.mepc;
        end else begin
            target = 32'd0;
        end
    end

    // Control flags.
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            rd_we     <= 1'b0;
            redirect  <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= rsp.valid;
            rd_we     <= rsp.rd_we;
            redirect  <= rsp.take_trap || rsp.take_mret;
            illegal   <= rsp.illegal;
        end
    end

    // Data loads every cycle, zero when unused.
    always_ff @(posedge clk) begin
        rd_data     <= rsp.rd_we ? rsp.old_value : 32'd0;
        redirect_pc <= target;
    end

    // CSR writeback and control transfer are exclusive.
    a_redirect_no_wb: assert property (
        @(posedge clk) disable iff (reset) !(redirect && rd_we)
    );

endmodule

//--- hdl/csr_unit_top.sv
`timescale 1ns/1ps

module csr_unit_top #(
    parameter logic [31:0] MTVEC_RESET = 32'h8000_0100
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_data,
    output logic        out_valid,
    output logic        rd_we,
    output logic [31:0] rd_data,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic        illegal
);

    csr_req_if req_bus ();
    csr_rsp_if rsp_bus ();

    // Combinational decode.
    csr_decode u_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .req         (req_bus.source)
    );

    // CSR state, updated on the accepting edge.
    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_file (
        .clk   (clk),
        .reset (reset),
        .req   (req_bus.sink),
        .rsp   (rsp_bus.source)
    );

    // Output registers, one cycle of latency.
    csr_result u_result (
        .clk         (clk),
        .reset       (reset),
        .rsp         (rsp_bus.sink),
        .out_valid   (out_valid),
        .rd_we       (rd_we),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .illegal     (illegal)
    );

endmodule

//--- sources.f
hdl/csr_pkg.sv
hdl/csr_ifs.sv
hdl/csr_decode.sv
hdl/csr_file.sv
hdl/csr_result.sv
hdl/csr_unit_top.sv
testbench/csr_unit_checker.sv
testbench/csr_unit_tb.sv

//--- testbench/csr_unit_checker.sv
`timescale 1ns/1ps

module csr_unit_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        check_en,
    input  logic [7:0]  test_id,
    input  logic [79:0] expected,
    input  logic        out_valid,
    input  logic        rd_we,
    input  logic [31:0] rd_data,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        illegal,
    output int          error_count
);

    logic        pend_en = 1'b0;
    logic        armed = 1'b0;
    logic [7:0]  pend_id;
    logic [79:0] pend_exp;
    int          errors = 0;
    int          check_count = 0;

    assign error_count = errors;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'h01:   return "reset_state";
            8'h02:   return "read_modify_write";
            8'h03:   return "fixed_value_csrs";
            8'h04:   return "ecall";
            8'h05:   return "mret";
            8'h06:   return "illegal_access";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compare_field(input string field, input logic [31:0] exp_value,
                                 input logic [31:0] act_value);
        check_count++;
        if (act_value !== exp_value) begin
            $display("FAILED %s %s expected %h actual %h",
                     test_name(pend_id), field, exp_value, act_value);
            errors++;
        end
    endtask

    task automatic report_counts();
        $display("Checks run: %0d, errors: %0d", check_count, errors);
    endtask

    // Expected values follow the inputs by one cycle, the DUT latency.
    always @(posedge clk) begin
        armed    <= 1'b1;
        pend_en  <= check_en && !reset;
        pend_id  <= test_id;
        pend_exp <= expected;
    end

    // Outputs settle after the rising edge, so compare on the falling one.
    always @(negedge clk) begin
        if (pend_en) begin
            if (pend_exp[79:76] != 4'h0 && out_valid !== 1'b1) begin
                $display("Missing out_valid in test %s, the DUT gave no result.",
                         test_name(pend_id));
                errors++;
            end else begin
                compare_field("out_valid", pend_exp[79:76], out_valid);
                compare_field("rd_we", pend_exp[75:72], rd_we);
                compare_field("rd_data", pend_exp[71:40], rd_data);
                compare_field("redirect", pend_exp[39:36], redirect);
                compare_field("redirect_pc", pend_exp[35:4], redirect_pc);
                compare_field("illegal", pend_exp[3:0], illegal);
            end
        end else if (armed) begin
            // Reset and idle cycles carry no result.
            if (out_valid !== 1'b0 || redirect !== 1'b0 || illegal !== 1'b0) begin
                $display("Output activity seen while no instruction was pending.");
                errors++;
            end
        end
    end

endmodule

//--- testbench/csr_unit_stim.txt
// name_valid_instr_pc_rs1data, then expected:
// out_valid_rd_we_rd_data_redirect_redirect_pc_illegal (one hex digit per flag)
01_1_300020F3_00000100_DEADBEEF_1_1_00001800_0_00000000_0
01_1_305020F3_00000104_00000000_1_1_80000100_0_00000000_0
01_1_341020F3_00000108_00000000_1_1_00000000_0_00000000_0
01_1_342020F3_0000010C_00000000_1_1_00000000_0_00000000_0
02_1_30529173_00000110_00002000_1_1_80000100_0_00000000_0
02_1_305321F3_00000114_000000F0_1_1_00002000_0_00000000_0
02_1_3053B273_00000118_00000030_1_1_000020F0_0_00000000_0
02_1_3050E2F3_0000011C_FFFFFFFF_1_1_000020C0_0_00000000_0
02_1_3050F373_00000120_FFFFFFFF_1_1_000020C1_0_00000000_0
02_1_305FD073_00000124_00000000_1_0_00000000_0_00000000_0
02_1_305020F3_00000128_00000000_1_1_0000001F_0_00000000_0
02_1_30529073_0000012C_00000400_1_0_00000000_0_00000000_0
03_1_300290F3_00000130_12345678_1_1_00001800_0_00000000_0
03_1_300020F3_00000134_00000000_1_1_00001800_0_00000000_0
03_1_342290F3_00000138_FFFFFFFF_1_1_00000000_0_00000000_0
03_1_342020F3_0000013C_00000000_1_1_0000000B_0_00000000_0
03_1_3423B0F3_00000140_FFFFFFFF_1_1_0000000B_0_00000000_0
04_1_00000073_00000800_00000000_1_0_00000000_1_00000400_0
04_1_341020F3_00000144_00000000_1_1_00000800_0_00000000_0
04_1_342020F3_00000148_00000000_1_1_0000000B_0_00000000_0
05_1_30200073_0000014C_00000000_1_0_00000000_1_00000800_0
05_1_34129073_00000150_00001234_1_0_00000000_0_00000000_0
05_1_30200073_00000154_00000000_1_0_00000000_1_00001234_0
05_1_00000073_00000A00_00000000_1_0_00000000_1_00000400_0
05_1_30200073_00000158_00000000_1_0_00000000_1_00000A00_0
06_1_301290F3_0000015C_FFFFFFFF_1_0_00000000_0_00000000_1
06_1_3433B0F3_00000160_FFFFFFFF_1_0_00000000_0_00000000_1
06_1_3052C0F3_00000164_FFFFFFFF_1_0_00000000_0_00000000_1
06_1_00100093_00000168_00000000_1_0_00000000_0_00000000_1
06_1_300020F3_0000016C_DEADBEEF_1_1_00001800_0_00000000_0
06_1_305020F3_00000170_DEADBEEF_1_1_00000400_0_00000000_0
06_1_341020F3_00000174_DEADBEEF_1_1_00000A00_0_00000000_0
06_1_342020F3_00000178_DEADBEEF_1_1_0000000B_0_00000000_0
06_0_00000000_00000000_00000000_0_0_00000000_0_00000000_0

//--- testbench/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;

    localparam int max_vectors = 64;

    logic         clk;
    logic         reset;
    logic         instr_valid;
    logic [31:0]  instr;
    logic [31:0]  pc;
    logic [31:0]  rs1_data;
    logic         out_valid;
    logic         rd_we;
    logic [31:0]  rd_data;
    logic         redirect;
    logic [31:0]  redirect_pc;
    logic         illegal;
    logic         check_en;
    logic [7:0]   test_id;
    logic [79:0]  expected;
    logic [187:0] vectors [0:max_vectors-1];
    logic         setup_error;
    int           num_vectors;
    int           idx;
    int           cycle_count;
    int           cycle_limit;
    int           error_count;

    csr_unit_top #(
        .MTVEC_RESET (32'h8000_0100)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .out_valid   (out_valid),
        .rd_we       (rd_we),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .illegal     (illegal)
    );

    csr_unit_checker check_i (
        .clk         (clk),
        .reset       (reset),
        .check_en    (check_en),
        .test_id     (test_id),
        .expected    (expected),
        .out_valid   (out_valid),
        .rd_we       (rd_we),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .illegal     (illegal),
        .error_count (error_count)
    );

    // 40 ns period.
    always #20 clk = ~clk;

    // Watchdog on the cycle count.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles.", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    // Vector layout: name, valid, instr, pc, rs1_data, then the expected outputs.
    task automatic apply_vector(input logic [187:0] vec);
        test_id     = vec[187:180];
        instr_valid = vec[176];
        instr       = vec[175:144];
        pc          = vec[143:112];
        rs1_data    = vec[111:80];
        expected    = vec[79:0];
        check_en    = 1'b1;
    endtask

    task automatic apply_idle();
        test_id     = 8'h00;
        instr_valid = 1'b0;
        instr       = 32'd0;
        pc          = 32'd0;
        rs1_data    = 32'd0;
        expected    = 80'd0;
        check_en    = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        setup_error = 1'b0;
        cycle_count = 0;
        cycle_limit = 0;
        apply_idle();
        $readmemh("testbench/csr_unit_stim.txt", vectors);
        // Unfilled entries stay unknown and mark the end of the list.
        num_vectors = 0;
        while (num_vectors < max_vectors && !$isunknown(vectors[num_vectors])) begin
            num_vectors++;
        end
        cycle_limit = num_vectors * 2 + 20;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        if (num_vectors == 0) begin
            $display("No vectors were read from the stimulus file.");
            setup_error = 1'b1;
        end
        // One vector per cycle, each 1 ns after the rising edge.
        for (idx = 0; idx < num_vectors; idx++) begin
            apply_vector(vectors[idx]);
            @(posedge clk);
            #1;
        end
        apply_idle();
        repeat (3) @(posedge clk);
        check_i.report_counts();
        if (setup_error || error_count != 0) begin
            $display("Test failures found");
        end else begin
            $display("All tests passed!");
        end
        $finish;
    end

endmodule
